//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;   // released on a falling edge
    end

endmodule

//--- dv/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam logic [31:0] base_address = 32'h100;
    localparam int          rom_depth    = 256;
    localparam int          wait_limit   = 64;   // cycles per wait loop
    localparam int          step_limit   = 1000;

    logic         clock;
    logic         reset;
    logic [31:0]  instr_addr;
    instruction_t instr_data;
    logic         out_valid;
    logic [31:0]  out_data;
    logic         halted;

    instruction_t rom [rom_depth];
    string        rom_tag [rom_depth];
    logic [7:0]   wr_idx;
    logic [31:0]  lcg_state = 32'h00fc_d726;
    logic [31:0]  exp_pc [$];    // fetch address per cycle, last entry is the frozen one
    logic [31:0]  exp_out [$];
    string        exp_tag [$];
    int           error_count = 0;
    int           timeout_count = 0;

    clock_gen #(.period_ns(8), .reset_cycles(8)) u_clock_gen (.clock(clock), .reset(reset));

    cpu_core #(.reset_address(base_address)) u_dut (
        .clock      (clock),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halted     (halted)
    );

    assign instr_data = fetch(instr_addr);   // combinational ROM

    function automatic instruction_t fetch(logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - base_address;
        if (offset[1:0] == 2'b00 && offset[31:10] == '0) begin
            return rom[offset[9:2]];
        end
        return encode(op_halt, 4'd0, 4'd0, 4'd0, 16'h0);
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic instruction_t encode(opcode_e op, logic [3:0] rd, logic [3:0] rs1,
                                            logic [3:0] rs2, logic [15:0] imm);
        return '{op, rd, rs1, rs2, imm};
    endfunction

    // **********************************************************************
    // program construction
    // **********************************************************************

    task automatic emit(instruction_t ins, string tag);
        rom[wr_idx] = ins;
        rom_tag[wr_idx] = tag;
        wr_idx = wr_idx + 8'd1;
    endtask

    task automatic load_imm(logic [3:0] rd, imm_type_e kind, logic [15:0] imm);
        emit(encode(op_ldi, rd, 4'd0, {2'b00, kind}, imm), "");
    endtask

    task automatic load_word(logic [3:0] rd, logic [31:0] value);
        load_imm(rd, it_unsigned, value[15:0]);
        load_imm(rd, it_top, value[31:16]);
    endtask

    task automatic show(logic [3:0] rd, string tag);
        emit(encode(op_out, rd, 4'd0, 4'd0, 16'h0), tag);
    endtask

    // marker in r10, target in r9; a taken branch skips the out
    task automatic branch_case(logic [3:0] cond, instruction_t setup, string tag);
        logic [31:0] target;
        load_imm(4'd10, it_unsigned, {8'h0, wr_idx});
        target = base_address + {22'h0, wr_idx + 8'd4, 2'b00};
        load_imm(4'd9, it_unsigned, target[15:0]);
        emit(setup, "");
        emit(encode(op_br, cond, 4'd9, 4'd0, 16'h0), "");
        show(4'd10, tag);
    endtask

    task automatic build_program();
        opcode_e      alu_ops [7];
        instruction_t equal;
        instruction_t below;
        instruction_t above;
        alu_ops = '{op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
        foreach (rom[i]) begin
            rom[i] = encode(op_halt, 4'd0, 4'd0, 4'd0, 16'(i));
            rom_tag[i] = "";
        end
        wr_idx = 8'd0;
        load_word(4'd1, next_random());
        show(4'd1, "ldi full word");
        load_imm(4'd1, it_bottom, 16'(next_random()));
        show(4'd1, "ldi bottom");
        load_imm(4'd1, it_top, 16'(next_random()));
        show(4'd1, "ldi top");
        load_imm(4'd2, it_unsigned, 16'(next_random()) | 16'h8000);
        show(4'd2, "ldi unsigned");
        load_imm(4'd2, it_signed, 16'(next_random()) | 16'h8000);
        show(4'd2, "ldi signed negative");
        load_imm(4'd2, it_signed, 16'(next_random()) & 16'h7fff);
        show(4'd2, "ldi signed positive");
        load_word(4'd3, next_random());
        load_word(4'd4, next_random());
        foreach (alu_ops[i]) begin
            emit(encode(alu_ops[i], 4'd5, 4'd3, 4'd4, 16'h0), "");
            show(4'd5, $sformatf("alu %s", alu_ops[i].name()));
        end
        load_word(4'd6, next_random() | 32'hffff_0000);
        load_word(4'd7, next_random() | 32'hf000_0000);
        emit(encode(op_add, 4'd5, 4'd6, 4'd7, 16'h0), "");
        show(4'd5, "alu add with carry");
        load_imm(4'd8, it_unsigned, 16'd31);
        emit(encode(op_shl, 4'd5, 4'd3, 4'd8, 16'h0), "");
        show(4'd5, "alu shl by 31");
        emit(encode(op_shr, 4'd5, 4'd3, 4'd8, 16'h0), "");
        show(4'd5, "alu shr by 31");
        load_imm(4'd12, it_unsigned, 16'd1);
        load_imm(4'd13, it_unsigned, 16'd2);
        load_word(4'd14, 32'h7fff_ffff);
        equal = encode(op_cmp, 4'd0, 4'd3, 4'd3, 16'h0);
        below = encode(op_cmp, 4'd0, 4'd12, 4'd13, 16'h0);   // borrow, negative
        above = encode(op_cmp, 4'd0, 4'd13, 4'd12, 16'h0);
        branch_case(bc_zero, equal, "branch zero set");
        branch_case(bc_zero, below, "branch zero clear");
        branch_case(bc_not_zero, below, "branch not zero set");
        branch_case(bc_not_zero, equal, "branch not zero clear");
        branch_case(bc_carry, below, "branch carry set");
        branch_case(bc_carry, above, "branch carry clear");
        branch_case(bc_neg, below, "branch neg set");
        branch_case(bc_neg, above, "branch neg clear");
        branch_case(bc_over, encode(op_add, 4'd15, 4'd14, 4'd12, 16'h0), "branch over set");
        branch_case(bc_over, encode(op_cmp, 4'd0, 4'd15, 4'd12, 16'h0), "branch over cmp");
        branch_case(bc_over, equal, "branch over clear");
        branch_case(bc_carry, encode(op_add, 4'd15, 4'd6, 4'd7, 16'h0), "branch carry add");
        branch_case(bc_always, above, "branch always");
        branch_case(4'd9, equal, "branch never");
        emit(encode(op_halt, 4'd0, 4'd0, 4'd0, 16'h0), "");
    endtask

    // **********************************************************************
    // reference interpreter
    // **********************************************************************

    task automatic run_reference();
        logic [31:0]  regs [16];
        logic [31:0]  pc;
        logic [31:0]  offset;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  r;
        logic [32:0]  wide;
        flags_t       f;
        instruction_t ins;
        logic         take;
        logic         done;
        int           steps;
        pc = base_address;
        f = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < step_limit) begin
            exp_pc.push_back(pc);
            ins = fetch(pc);
            offset = pc - base_address;
            a = regs[ins.rs1];
            b = regs[ins.rs2];
            r = '0;
            pc = pc + 32'd4;
            case (ins.opcode)
                op_add: begin
                    r = a + b;
                    wide = {a[31], a} + {b[31], b};
                    f = '{r < a, r == 32'h0, r[31], wide[32] != wide[31]};
                end
                op_sub, op_cmp: begin
                    r = a - b;
                    wide = {a[31], a} - {b[31], b};
                    f = '{a < b, r == 32'h0, r[31], wide[32] != wide[31]};
                end
                op_and:  r = a & b;
                op_or:   r = a | b;
                op_xor:  r = a ^ b;
                op_shl:  r = a << b[4:0];
                op_shr:  r = a >> b[4:0];
                op_ldi: begin
                    case (imm_type_e'(ins.rs2[1:0]))
                        it_bottom:   regs[ins.rd] = {regs[ins.rd][31:16], ins.imm};
                        it_top:      regs[ins.rd] = {ins.imm, regs[ins.rd][15:0]};
                        it_unsigned: regs[ins.rd] = {16'h0, ins.imm};
                        default:     regs[ins.rd] = {{16{ins.imm[15]}}, ins.imm};
                    endcase
                end
                op_br: begin
                    case (branch_cond_e'(ins.rd))
                        bc_always:   take = 1'b1;
                        bc_zero:     take = f.zero;
                        bc_not_zero: take = !f.zero;
                        bc_carry:    take = f.carry;
                        bc_neg:      take = f.neg;
                        bc_over:     take = f.over;
                        default:     take = 1'b0;
                    endcase
                    if (take) begin
                        pc = a;
                    end
                end
                op_out: begin
                    exp_out.push_back(regs[ins.rd]);
                    exp_tag.push_back(rom_tag[offset[9:2]]);
                end
                op_halt: begin
                    done = 1'b1;
                    exp_pc.push_back(pc);   // address seen while halted
                end
                default: ;
            endcase
            if (ins.opcode inside {[op_and:op_shr]}) begin
                f = '{1'b0, r == 32'h0, r[31], 1'b0};
            end
            if (ins.opcode inside {[op_add:op_shr]}) begin
                regs[ins.rd] = r;
            end
            steps++;
        end
        if (!done) begin
            $display("reference program never reached its halt instruction");
            error_count++;
        end
    endtask

    // advance one cycle and check the fetch address on the falling edge
    task automatic step_cycle();
        @(negedge clock);
        if (exp_pc.size() > 1) begin
            void'(exp_pc.pop_front());
        end
        assert (instr_addr == exp_pc[0]) else begin
            $display("Error fetch address: expected %h, actual %h", exp_pc[0], instr_addr);
            error_count++;
        end
    endtask

    initial begin
        int          waited;
        logic [31:0] frozen;
        build_program();
        run_reference();
        @(posedge clock);
        waited = 0;
        while (reset && waited < wait_limit) begin
            @(negedge clock);
            assert (instr_addr == base_address && !out_valid && !halted) else begin
                $display("Error reset state: expected %h, actual %h",
                         {base_address, 2'b00}, {instr_addr, out_valid, halted});
                error_count++;
            end
            @(posedge clock);
            waited++;
        end
        if (reset) begin
            $display("reset was never released");
            timeout_count++;
        end
        while (timeout_count == 0 && exp_out.size() > 0) begin
            waited = 0;
            do begin
                step_cycle();
                waited++;
            end while (!out_valid && waited < wait_limit);
            if (out_valid) begin
                assert (out_data == exp_out[0]) else begin
                    $display("Error %s: expected %h, actual %h", exp_tag[0], exp_out[0], out_data);
                    error_count++;
                end
                void'(exp_out.pop_front());
                void'(exp_tag.pop_front());
            end else begin
                $display("no output beat arrived for %s", exp_tag[0]);
                timeout_count++;
            end
        end
        waited = 0;
        while (timeout_count == 0 && !halted && waited < wait_limit) begin
            step_cycle();
            waited++;
            assert (!out_valid) else begin
                $display("an output beat appeared that the program does not produce");
                error_count++;
            end
        end
        if (timeout_count == 0 && !halted) begin
            $display("the core never reported halted");
            timeout_count++;
        end
        if (timeout_count == 0) begin
            frozen = instr_addr;
            repeat (20) begin
                step_cycle();
                assert (halted && !out_valid && instr_addr == frozen) else begin
                    $display("Error halt hold: expected %h, actual %h",
                             {frozen, 2'b10}, {instr_addr, halted, out_valid});
                    error_count++;
                end
            end
        end
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
src/cpu_pkg.sv
src/register_file.sv
src/program_counter.sv
src/status_register.sv
src/alu.sv
src/instruction_decoder.sv
src/cpu_core.sv
dv/clock_gen.sv
dv/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu_core -f filelist.f

output=$(./obj_dir/Vtb_cpu_core)
echo "$output"

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_e                op,
    input  logic [cpu_pkg::data_width-1:0]  a,
    input  logic [cpu_pkg::data_width-1:0]  b,
    output logic [cpu_pkg::data_width-1:0]  result,
    output cpu_pkg::flags_t                 flags_next
);
    import cpu_pkg::*;

    localparam int msb = data_width - 1;

    logic [data_width:0] sum;    // bit 32 is carry out
    logic [data_width:0] diff;   // bit 32 is borrow
    logic                add_over;
    logic                sub_over;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // signed overflow from operand and result signs
    assign add_over = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
    assign sub_over = (a[msb] != b[msb]) && (diff[msb] != a[msb]);

    always_comb begin
        result           = '0;
        flags_next.carry = 1'b0;   // logic and shifts clear carry/over
        flags_next.over  = 1'b0;
        case (op)
            op_add: begin
                result           = sum[msb:0];
                flags_next.carry = sum[data_width];
                flags_next.over  = add_over;
            end
            op_sub, op_cmp: begin
                result           = diff[msb:0];
                flags_next.carry = diff[data_width];
                flags_next.over  = sub_over;
            end
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_shl:  result = a << b[4:0];
            op_shr:  result = a >> b[4:0];
            default: result = '0;
        endcase
        flags_next.zero = (result == '0);
        flags_next.neg  = result[msb];
    end

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [cpu_pkg::data_width-1:0] reset_address = '0
) (
    input  logic                            clock,
    input  logic                            reset,
    output logic [cpu_pkg::data_width-1:0]  instr_addr,
    input  cpu_pkg::instruction_t           instr_data,
    output logic                            out_valid,
    output logic [cpu_pkg::data_width-1:0]  out_data,
    output logic                            halted
);
    import cpu_pkg::*;

    ctrl_t                 ctrl;
    flags_t                flags;
    flags_t                flags_next;
    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic [data_width-1:0] rd_data;
    logic [data_width-1:0] alu_result;

    // **********************************************************************
    // state elements
    // **********************************************************************

    register_file u_register_file (
        .clock                (clock),
        .write_index          (instr_data.rd),
        .write                (ctrl.reg_write),
        .write_data           (alu_result),
        .write_immediate      (ctrl.imm_write),
        .write_immediate_data (instr_data.imm),
        .write_immediate_type (ctrl.imm_type),
        .read_reg1_index      (instr_data.rs1),
        .read_reg2_index      (instr_data.rs2),
        .read_reg3_index      (instr_data.rd),   // merge source and out value
        .read_reg1_data       (rs1_data),
        .read_reg2_data       (rs2_data),
        .read_reg3_data       (rd_data)
    );

    program_counter #(.reset_address(reset_address)) u_program_counter (
        .clock     (clock),
        .reset     (reset),
        .jump      (ctrl.jump),
        .inc       (ctrl.inc),
        .jump_data (rs1_data),   // jump through register
        .read_data (instr_addr)
    );

    status_register u_status_register (
        .clock    (clock),
        .reset    (reset),
        .write    (ctrl.flags_write),
        .flags_in (flags_next),
        .flags    (flags)
    );

    alu u_alu (
        .op         (ctrl.alu_op),
        .a          (rs1_data),
        .b          (rs2_data),
        .result     (alu_result),
        .flags_next (flags_next)
    );

    instruction_decoder u_instruction_decoder (
        .instr  (instr_data),
        .flags  (flags),
        .halted (halted),
        .ctrl   (ctrl)
    );

    // output port and halt state
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            out_valid <= ctrl.out_strobe;   // one cycle pulse
            if (ctrl.halt_set) begin
                halted <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.out_strobe) begin
            out_data <= rd_data;
        end
    end

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

    // **********************************************************************
    // widths
    // **********************************************************************

    localparam int data_width      = 32;
    localparam int reg_index_width = 4;
    localparam int imm_width       = 16;

    // **********************************************************************
    // encodings
    // **********************************************************************

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_shl  = 4'd6,   // logical, by b[4:0]
        op_shr  = 4'd7,
        op_cmp  = 4'd8,   // sub without register write
        op_ldi  = 4'd9,
        op_br   = 4'd10,
        op_out  = 4'd11,
        op_halt = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        it_bottom   = 2'd0,   // bits 15:0 replaced
        it_top      = 2'd1,   // bits 31:16 replaced
        it_unsigned = 2'd2,
        it_signed   = 2'd3
    } imm_type_e;

    // codes above bc_over never jump
    typedef enum logic [3:0] {
        bc_always   = 4'd0,
        bc_zero     = 4'd1,
        bc_not_zero = 4'd2,
        bc_carry    = 4'd3,
        bc_neg      = 4'd4,
        bc_over     = 4'd5
    } branch_cond_e;

    // **********************************************************************
    // structs
    // **********************************************************************

    typedef struct packed {
        opcode_e                     opcode;
        logic [reg_index_width-1:0]  rd;    // branch condition for op_br
        logic [reg_index_width-1:0]  rs1;
        logic [reg_index_width-1:0]  rs2;   // low bits give imm type for op_ldi
        logic [imm_width-1:0]        imm;
    } instruction_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic neg;
        logic over;
    } flags_t;

    typedef struct packed {
        logic      reg_write;
        logic      imm_write;
        imm_type_e imm_type;
        logic      flags_write;
        logic      jump;
        logic      inc;
        logic      out_strobe;
        logic      halt_set;
        opcode_e   alu_op;
    } ctrl_t;

endpackage

//--- src/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  cpu_pkg::instruction_t  instr,
    input  cpu_pkg::flags_t        flags,
    input  logic                   halted,
    output cpu_pkg::ctrl_t         ctrl
);
    import cpu_pkg::*;

    branch_cond_e cond;
    logic         taken;

    assign cond = branch_cond_e'(instr.rd);

    always_comb begin
        case (cond)
            bc_always:   taken = 1'b1;
            bc_zero:     taken = flags.zero;
            bc_not_zero: taken = !flags.zero;
            bc_carry:    taken = flags.carry;
            bc_neg:      taken = flags.neg;
            bc_over:     taken = flags.over;
            default:     taken = 1'b0;
        endcase
    end

    // **********************************************************************
    // opcode to control
    // **********************************************************************

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = instr.opcode;
        ctrl.imm_type = imm_type_e'(instr.rs2[1:0]);
        ctrl.inc      = 1'b1;
        case (instr.opcode)
            op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr: begin
                ctrl.reg_write   = 1'b1;
                ctrl.flags_write = 1'b1;
            end
            op_cmp:  ctrl.flags_write = 1'b1;   // flags only
            op_ldi:  ctrl.imm_write = 1'b1;
            op_br: begin
                ctrl.jump = taken;
                ctrl.inc  = !taken;
            end
            op_out:  ctrl.out_strobe = 1'b1;
            op_halt: ctrl.halt_set = 1'b1;
            default: ctrl.alu_op = op_nop;   // unused codes act as nop
        endcase
        if (halted) begin
            ctrl = '0;   // core frozen
        end
    end

endmodule

//--- src/program_counter.sv
`timescale 1ns/1ps

module program_counter #(
    parameter logic [cpu_pkg::data_width-1:0] reset_address = '0
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            jump,
    input  logic                            inc,
    input  logic [cpu_pkg::data_width-1:0]  jump_data,
    output logic [cpu_pkg::data_width-1:0]  read_data
);
    import cpu_pkg::*;

    logic [data_width-1:0] pc;

    assign read_data = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_address;
        end else if (jump) begin
            pc <= jump_data;
        end else if (inc) begin
            pc <= pc + data_width'(4);   // one word per instruction
        end
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                                 clock,
    input  logic [cpu_pkg::reg_index_width-1:0]  write_index,
    input  logic                                 write,
    input  logic [cpu_pkg::data_width-1:0]       write_data,
    input  logic                                 write_immediate,
    input  logic [cpu_pkg::imm_width-1:0]        write_immediate_data,
    input  cpu_pkg::imm_type_e                   write_immediate_type,
    input  logic [cpu_pkg::reg_index_width-1:0]  read_reg1_index,
    input  logic [cpu_pkg::reg_index_width-1:0]  read_reg2_index,
    input  logic [cpu_pkg::reg_index_width-1:0]  read_reg3_index,
    output logic [cpu_pkg::data_width-1:0]       read_reg1_data,
    output logic [cpu_pkg::data_width-1:0]       read_reg2_data,
    output logic [cpu_pkg::data_width-1:0]       read_reg3_data
);
    import cpu_pkg::*;

    logic [data_width-1:0] regs [2**reg_index_width];

    assign read_reg1_data = regs[read_reg1_index];
    assign read_reg2_data = regs[read_reg2_index];
    assign read_reg3_data = regs[read_reg3_index];

    always_ff @(posedge clock) begin
        if (write) begin
            regs[write_index] <= write_data;   // full write wins
        end else if (write_immediate) begin
            case (write_immediate_type)
                it_bottom:   regs[write_index][15:0] <= write_immediate_data;
                it_top:      regs[write_index][31:16] <= write_immediate_data;
                it_unsigned: regs[write_index] <= {16'h0, write_immediate_data};
                it_signed: begin
                    regs[write_index] <= {{16{write_immediate_data[15]}},
                                          write_immediate_data};
                end
            endcase
        end
    end

endmodule

//--- src/status_register.sv
`timescale 1ns/1ps

module status_register (
    input  logic             clock,
    input  logic             reset,
    input  logic             write,
    input  cpu_pkg::flags_t  flags_in,
    output cpu_pkg::flags_t  flags
);
    import cpu_pkg::*;

    flags_t flags_q;

    assign flags = flags_q;

    // all four flags move together
    always_ff @(posedge clock) begin
        if (reset) begin
            flags_q <= '0;
        end else if (write) begin
            flags_q <= flags_in;
        end
    end

endmodule
